// File: flist.f
+incdir+rtl
rtl/capi_pkg.sv
rtl/afu_pkg.sv
rtl/command_issue.sv
rtl/tag_table.sv
rtl/response_control.sv
rtl/afu_response_top.sv
verif/tb_afu_response.sv

// File: rtl/afu_pkg.sv
`include "afu_settings.svh"

package afu_pkg;
  import capi_pkg::*;

  typedef enum logic [2:0] {
    CMD_INVALID = 3'd0,
    CMD_READ    = 3'd1,
    CMD_WRITE   = 3'd2,
    CMD_WED     = 3'd3,
    CMD_RESTART = 3'd4
  } command_type_t;

  // what the tag table keeps per outstanding tag
  typedef struct packed {
    command_type_t            cmd_type;
    logic [`AFU_TAG_BITS-1:0] tag;
    logic [15:0]              address;
  } CommandTagLine;

  typedef struct packed {
    logic          valid;
    CommandTagLine cmd;
  } CommandInterface;

  typedef struct packed {
    logic           valid;
    CommandTagLine  cmd;      // line stored at issue time
    response_code_t response;
  } ResponseControlLine;

  typedef struct packed {
    logic               read_response;
    logic               write_response;
    logic               wed_response;
    logic               restart_response;
    ResponseControlLine response;
  } ResponseControlInterfaceOut;

endpackage

// File: rtl/afu_response_top.sv
`timescale 1ns/10ps
`include "afu_settings.svh"

module afu_response_top
  import capi_pkg::*;
  import afu_pkg::*;
(
  input  logic                           clock,
  input  logic                           rstn,
  input  logic                           enabled_in,
  // wishbone command port
  input  logic                           wb_cyc,
  input  logic                           wb_stb,
  input  logic                           wb_we,
  input  logic [`AFU_WB_ADDR_BITS-1:0]   wb_adr,
  input  logic [`AFU_WB_DATA_BITS-1:0]   wb_dat_w,
  input  logic [`AFU_WB_DATA_BITS/8-1:0] wb_sel,
  output logic                           wb_ack,
  output logic [`AFU_WB_DATA_BITS-1:0]   wb_dat_r,
  output CommandInterface                cmd_out,
  // link response side
  input  ResponseInterface               response,
  output logic [0:6]                     response_error,
  output ResponseControlInterfaceOut     response_control_out
);

  logic                                free_valid;
  logic [`AFU_TAG_BITS-1:0]            free_tag;
  logic                                alloc;
  CommandTagLine                       alloc_line;
  logic [$clog2(`AFU_TAG_COUNT+1)-1:0] outstanding;
  logic [`AFU_TAG_BITS-1:0]            lookup_tag;
  CommandTagLine                       lookup_line;
  logic                                release_valid;
  logic [`AFU_TAG_BITS-1:0]            release_tag;

  command_issue command_issue_inst (
    .clock       (clock),
    .rstn        (rstn),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_sel      (wb_sel),
    .wb_ack      (wb_ack),
    .wb_dat_r    (wb_dat_r),
    .free_valid  (free_valid),
    .free_tag    (free_tag),
    .alloc       (alloc),
    .alloc_line  (alloc_line),
    .outstanding (outstanding),
    .cmd_out     (cmd_out)
  );

  tag_table tag_table_inst (
    .clock         (clock),
    .rstn          (rstn),
    .alloc         (alloc),
    .alloc_line    (alloc_line),
    .release_valid (release_valid),
    .release_tag   (release_tag),
    .lookup_tag    (lookup_tag),
    .lookup_line   (lookup_line),
    .free_valid    (free_valid),
    .free_tag      (free_tag),
    .outstanding   (outstanding)
  );

  response_control response_control_inst (
    .clock                (clock),
    .rstn                 (rstn),
    .enabled_in           (enabled_in),
    .response             (response),
    .lookup_tag           (lookup_tag),
    .response_tag_id_in   (lookup_line),
    .release_valid        (release_valid),
    .release_tag          (release_tag),
    .response_error       (response_error),
    .response_control_out (response_control_out)
  );

endmodule

// File: rtl/afu_settings.svh
`ifndef AFU_SETTINGS_SVH
`define AFU_SETTINGS_SVH

// tag field width on the command and response ports
`define AFU_TAG_BITS 8
`define AFU_TAG_COUNT 16 // tags handed out, low end of the tag space

// wishbone command port
`define AFU_WB_DATA_BITS 32
`define AFU_WB_ADDR_BITS 4

`endif

// File: rtl/capi_pkg.sv
`include "afu_settings.svh"

package capi_pkg;

  // response codes returned by the link
  typedef enum logic [7:0] {
    DONE    = 8'h00,
    AERROR  = 8'h01,
    DERROR  = 8'h03,
    FAULT   = 8'h05,
    FAILED  = 8'h07,
    FLUSHED = 8'h0a,
    PAGED   = 8'h0b
  } response_code_t;

  typedef struct packed {
    logic                     valid;
    logic [`AFU_TAG_BITS-1:0] tag;
    logic                     tag_parity; // odd parity over tag
    response_code_t           response;
  } ResponseInterface;

  // bit that makes tag plus parity hold an odd number of ones
  function automatic logic odd_parity_of(input logic [`AFU_TAG_BITS-1:0] tag);
    return ~(^tag);
  endfunction

  // one-hot error field, aerror first and paged last
  function automatic logic [0:5] cmd_response_error_type(input response_code_t code);
    logic [0:5] err;
    err = 6'b000000;
    case (code)
      AERROR  : err[0] = 1'b1;
      DERROR  : err[1] = 1'b1;
      FAULT   : err[2] = 1'b1;
      FAILED  : err[3] = 1'b1;
      FLUSHED : err[4] = 1'b1;
      PAGED   : err[5] = 1'b1;
      default : err = 6'b000000; // done and anything unknown
    endcase
    return err;
  endfunction

endpackage

// File: rtl/command_issue.sv
`timescale 1ns/10ps
`include "afu_settings.svh"

module command_issue
  import afu_pkg::*;
(
  input  logic                                 clock,
  input  logic                                 rstn,
  // wishbone classic slave
  input  logic                                 wb_cyc,
  input  logic                                 wb_stb,
  input  logic                                 wb_we,
  input  logic [`AFU_WB_ADDR_BITS-1:0]         wb_adr,
  input  logic [`AFU_WB_DATA_BITS-1:0]         wb_dat_w,
  input  logic [`AFU_WB_DATA_BITS/8-1:0]       wb_sel,
  output logic                                 wb_ack,
  output logic [`AFU_WB_DATA_BITS-1:0]         wb_dat_r,
  // tag allocation
  input  logic                                 free_valid,
  input  logic [`AFU_TAG_BITS-1:0]             free_tag,
  output logic                                 alloc,
  output CommandTagLine                        alloc_line,
  input  logic [$clog2(`AFU_TAG_COUNT+1)-1:0]  outstanding,
  // command port
  output CommandInterface                      cmd_out
);

  typedef enum logic [1:0] {
    IDLE,
    STALL,
    ACK
  } issue_state_t;

  localparam int data_bits = `AFU_WB_DATA_BITS;
  localparam logic [`AFU_WB_ADDR_BITS-1:0] cmd_addr    = 'd0;
  localparam logic [`AFU_WB_ADDR_BITS-1:0] status_addr = 'd1;

  issue_state_t  state;
  command_type_t wr_type;
  logic          request;
  logic          cmd_write;
  logic          status_read;
  logic          accept;
  CommandTagLine next_line;

  assign request = wb_cyc && wb_stb;
  assign wr_type = command_type_t'(wb_dat_w[2:0]);

  // type sits in byte 0, address in bytes 3:2
  assign cmd_write = wb_we && (wb_adr == cmd_addr) && wb_sel[0] && (&wb_sel[3:2]) &&
                     (wr_type inside {CMD_READ, CMD_WRITE, CMD_WED, CMD_RESTART});
  assign status_read = !wb_we && (wb_adr == status_addr);

  // a command write waits here for a free tag
  assign accept = request && (state != ACK) && (!cmd_write || free_valid);

  always_comb begin
    next_line          = '0;
    next_line.cmd_type = wr_type;
    next_line.tag      = free_tag;
    next_line.address  = wb_dat_w[31:16];
  end

  ////////////////////////////////////////
  // wishbone cycle decode
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state    <= IDLE;
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
      cmd_out  <= '0;
    end else begin
      wb_ack        <= accept;
      cmd_out.valid <= accept && cmd_write;
      if (accept) begin
        cmd_out.cmd <= next_line;
        wb_dat_r    <= status_read ? data_bits'(outstanding) : '0;
      end
      case (state)
        IDLE, STALL : begin
          if (!request) begin
            state <= IDLE; // also covers an abandoned stall
          end else if (accept) begin
            state <= ACK;
          end else begin
            state <= STALL;
          end
        end
        ACK     : state <= IDLE;
        default : state <= IDLE;
      endcase
    end
  end

  // table takes the tag in the ack cycle
  assign alloc      = cmd_out.valid;
  assign alloc_line = cmd_out.cmd;

  ack_needs_request: assert property (@(posedge clock) disable iff (!rstn)
    wb_ack |-> (wb_cyc && wb_stb));

endmodule

// File: rtl/response_control.sv
`timescale 1ns/10ps
`include "afu_settings.svh"

module response_control
  import capi_pkg::*;
  import afu_pkg::*;
(
  input  logic                        clock,
  input  logic                        rstn,
  input  logic                        enabled_in,
  input  ResponseInterface            response,
  output logic [`AFU_TAG_BITS-1:0]    lookup_tag,
  input  CommandTagLine               response_tag_id_in,
  output logic                        release_valid,
  output logic [`AFU_TAG_BITS-1:0]    release_tag,
  output logic [0:6]                  response_error,
  output ResponseControlInterfaceOut  response_control_out
);

  logic             enabled;
  ResponseInterface response_in;
  logic             tag_parity_error;
  logic [0:5]       cmd_response_error;
  logic [0:6]       detected_errors;
  logic [3:0]       route_flags;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enabled_in;
    end
  end

  ////////////////////////////////////////
  // response latch
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      response_in <= '0;
    end else begin
      if (enabled && response.valid) begin
        response_in <= response;
      end else begin
        response_in <= '0; // keeps the error stages quiet
      end
    end
  end

  assign lookup_tag = response_in.tag;

  // free the tag on the edge that routes its response
  assign release_valid = response_in.valid && (response_tag_id_in.cmd_type != CMD_INVALID);
  assign release_tag   = response_in.tag;

  ////////////////////////////////////////
  // routing by command type
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      response_control_out <= '0;
    end else begin
      response_control_out <= '0;
      if (response_in.valid) begin
        case (response_tag_id_in.cmd_type)
          CMD_READ    : response_control_out.read_response    <= 1'b1;
          CMD_WRITE   : response_control_out.write_response   <= 1'b1;
          CMD_WED     : response_control_out.wed_response     <= 1'b1;
          CMD_RESTART : response_control_out.restart_response <= 1'b1;
          default     : ; // tag not outstanding, echo only
        endcase
        response_control_out.response.valid    <= 1'b1;
        response_control_out.response.cmd      <= response_tag_id_in;
        response_control_out.response.response <= response_in.response;
      end
    end
  end

  ////////////////////////////////////////
  // parity and error pipeline
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_parity_error   <= 1'b0;
      cmd_response_error <= '0;
      detected_errors    <= '0;
      response_error     <= '0;
    end else begin
      tag_parity_error   <= response_in.valid &&
                            (odd_parity_of(response_in.tag) != response_in.tag_parity);
      cmd_response_error <= cmd_response_error_type(response_in.response);
      detected_errors    <= {tag_parity_error, cmd_response_error};
      response_error     <= detected_errors; // parity in bit 0
    end
  end

  assign route_flags = {response_control_out.read_response,
                        response_control_out.write_response,
                        response_control_out.wed_response,
                        response_control_out.restart_response};

  // a raised flag is single and carries the line of the answered tag
  one_route_per_response: assert property (@(posedge clock) disable iff (!rstn)
    (|route_flags) |-> ($onehot(route_flags) &&
                        (response_control_out.response.cmd.tag == $past(response_in.tag))));

endmodule

// File: rtl/tag_table.sv
`timescale 1ns/10ps
`include "afu_settings.svh"

module tag_table
  import afu_pkg::*;
(
  input  logic                                 clock,
  input  logic                                 rstn,
  input  logic                                 alloc,
  input  CommandTagLine                        alloc_line,
  input  logic                                 release_valid,
  input  logic [`AFU_TAG_BITS-1:0]             release_tag,
  input  logic [`AFU_TAG_BITS-1:0]             lookup_tag,
  output CommandTagLine                        lookup_line,
  output logic                                 free_valid,
  output logic [`AFU_TAG_BITS-1:0]             free_tag,
  output logic [$clog2(`AFU_TAG_COUNT+1)-1:0]  outstanding
);

  localparam int index_bits = $clog2(`AFU_TAG_COUNT);
  localparam int tag_bits   = `AFU_TAG_BITS;

  logic [`AFU_TAG_COUNT-1:0] busy;
  CommandTagLine             lines [`AFU_TAG_COUNT];
  logic [index_bits-1:0]     alloc_idx;
  logic [index_bits-1:0]     release_idx;
  logic [index_bits-1:0]     lookup_idx;
  logic                      lookup_hit;

  assign alloc_idx   = alloc_line.tag[index_bits-1:0];
  assign release_idx = release_tag[index_bits-1:0];
  assign lookup_idx  = lookup_tag[index_bits-1:0];

  ////////////////////////////////////////
  // busy flags and outstanding count
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      busy        <= '0;
      outstanding <= '0;
    end else begin
      if (release_valid) busy[release_idx] <= 1'b0;
      if (alloc) busy[alloc_idx] <= 1'b1; // alloc wins on the same tag
      case ({alloc, release_valid})
        2'b10   : outstanding <= outstanding + 1'b1;
        2'b01   : outstanding <= outstanding - 1'b1;
        default : outstanding <= outstanding;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) lines[alloc_idx] <= alloc_line;
  end

  // lowest free tag wins
  always_comb begin
    free_valid = 1'b0;
    free_tag   = '0;
    for (int i = `AFU_TAG_COUNT - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_valid = 1'b1;
        free_tag   = tag_bits'(i);
      end
    end
  end

  assign lookup_hit = (lookup_tag < `AFU_TAG_COUNT) && busy[lookup_idx];

  always_comb begin
    lookup_line = lines[lookup_idx];
    if (!lookup_hit) begin
      lookup_line          = '0;
      lookup_line.cmd_type = CMD_INVALID; // stale or unknown tag
      lookup_line.tag      = lookup_tag;
    end
  end

  alloc_on_free: assert property (@(posedge clock) disable iff (!rstn)
    alloc |-> !busy[alloc_idx]);

  release_on_busy: assert property (@(posedge clock) disable iff (!rstn)
    release_valid |-> busy[release_idx]);

endmodule

// File: run.sh
#!/bin/sh
# build and run the afu response testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_afu_response \
  -f flist.f -Mdir obj_dir -o sim_afu_response > build.log 2>&1 \
  && ./obj_dir/sim_afu_response > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation reported failure"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"

// File: verif/tb_afu_response.sv
`timescale 1ns/10ps
`include "afu_settings.svh"

module tb_afu_response
  import capi_pkg::*;
  import afu_pkg::*;
();

  localparam int clock_period   = 100;
  localparam int timeout_cycles = 20000;
  localparam int tag_count      = `AFU_TAG_COUNT;

  logic                           clock;
  logic                           rstn;
  logic                           enabled_in;
  logic                           wb_cyc;
  logic                           wb_stb;
  logic                           wb_we;
  logic [`AFU_WB_ADDR_BITS-1:0]   wb_adr;
  logic [`AFU_WB_DATA_BITS-1:0]   wb_dat_w;
  logic [`AFU_WB_DATA_BITS/8-1:0] wb_sel;
  logic                           wb_ack;
  logic [`AFU_WB_DATA_BITS-1:0]   wb_dat_r;
  CommandInterface                cmd_out;
  ResponseInterface               response;
  logic [0:6]                     response_error;
  ResponseControlInterfaceOut     response_control_out;

  // reference model of the tag table
  logic                       busy_model [tag_count];
  CommandTagLine              line_model [tag_count];
  int                         outstanding_model;
  logic                       enabled_model;
  ResponseControlInterfaceOut route_slot [8]; // expected outputs, indexed by cycle
  logic [0:6]                 error_slot [8];
  response_code_t             codes [7] = '{DONE, AERROR, DERROR, FAULT, FAILED, FLUSHED, PAGED};
  integer                     seed;
  int                         cycles = 0;
  int                         issued_cmds = 0;
  int                         seen_cmds = 0;
  int                         mismatches = 0;
  int                         other_errors = 0;
  logic                       got_ack;

  afu_response_top uut (
    .clock                (clock),
    .rstn                 (rstn),
    .enabled_in           (enabled_in),
    .wb_cyc               (wb_cyc),
    .wb_stb               (wb_stb),
    .wb_we                (wb_we),
    .wb_adr               (wb_adr),
    .wb_dat_w             (wb_dat_w),
    .wb_sel               (wb_sel),
    .wb_ack               (wb_ack),
    .wb_dat_r             (wb_dat_r),
    .cmd_out              (cmd_out),
    .response             (response),
    .response_error       (response_error),
    .response_control_out (response_control_out)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles, %0d mismatches, %0d other errors",
               cycles, mismatches, other_errors);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    mismatches++;
    $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  // bit that gives tag plus parity an odd count of ones
  function automatic logic parity_bit(input logic [7:0] tag);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) ones += tag[i];
    return (ones % 2) == 0;
  endfunction

  function automatic logic [0:6] expected_errors(input logic bad_parity,
                                                 input response_code_t code);
    logic [0:6] err;
    err    = '0;
    err[0] = bad_parity;
    case (code)
      AERROR  : err[1] = 1'b1;
      DERROR  : err[2] = 1'b1;
      FAULT   : err[3] = 1'b1;
      FAILED  : err[4] = 1'b1;
      FLUSHED : err[5] = 1'b1;
      PAGED   : err[6] = 1'b1;
      default : err[1:6] = '0;
    endcase
    return err;
  endfunction

  function automatic int lowest_free();
    for (int i = 0; i < tag_count; i++) begin
      if (!busy_model[i]) return i;
    end
    return -1;
  endfunction

  // first outstanding tag at or after start, wrapping
  function automatic logic [7:0] pick_tag(input int start);
    for (int i = 0; i < tag_count; i++) begin
      if (busy_model[(start + i) % tag_count]) return 8'((start + i) % tag_count);
    end
    return 8'(start + tag_count);
  endfunction

  ////////////////////////////////////////
  // wishbone master and response driver
  ////////////////////////////////////////

  task automatic wishbone_access(input logic we, input logic [3:0] adr, input logic [31:0] data);
    command_type_t wtype;
    logic          valid_cmd;
    int            tag;
    CommandTagLine exp_line;
    wtype     = command_type_t'(data[2:0]);
    valid_cmd = we && (adr == 4'd0) && (wtype inside {CMD_READ, CMD_WRITE, CMD_WED, CMD_RESTART});
    wb_cyc    = 1'b1;
    wb_stb    = 1'b1;
    wb_we     = we;
    wb_adr    = adr;
    wb_dat_w  = data;
    got_ack   = 1'b0;
    do begin
      next_cycle();
    end while (!wb_ack);
    got_ack = 1'b1;
    if (cmd_out.valid !== valid_cmd) report_mismatch("cmd_out.valid", cmd_out.valid, valid_cmd);
    if (valid_cmd) begin
      tag = lowest_free();
      if (tag < 0) begin
        other_errors++;
        $display("command acknowledged at %0t although no tag was free", $time);
      end else begin
        exp_line = '{cmd_type: wtype, tag: 8'(tag), address: data[31:16]};
        if (cmd_out.cmd !== exp_line) report_mismatch("cmd_out.cmd", cmd_out.cmd, exp_line);
        busy_model[tag] = 1'b1;
        line_model[tag] = exp_line;
        outstanding_model++;
        issued_cmds++;
      end
    end
    if (!we && wb_dat_r !== ((adr == 4'd1) ? outstanding_model : 0)) begin
      report_mismatch("wb_dat_r", wb_dat_r, (adr == 4'd1) ? outstanding_model : 0);
    end
    next_cycle(); // cycle ends on the edge that samples ack
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic send_response(input logic [7:0] tag, input logic good_parity,
                               input response_code_t code);
    ResponseControlInterfaceOut exp_route;
    response.valid      = 1'b1;
    response.tag        = tag;
    response.tag_parity = parity_bit(tag) ^ !good_parity;
    response.response   = code;
    exp_route           = '0;
    if (enabled_model) begin
      exp_route.response.valid    = 1'b1;
      exp_route.response.response = code;
      if (tag < tag_count && busy_model[tag]) begin
        exp_route.response.cmd = line_model[tag];
        case (line_model[tag].cmd_type)
          CMD_READ    : exp_route.read_response    = 1'b1;
          CMD_WRITE   : exp_route.write_response   = 1'b1;
          CMD_WED     : exp_route.wed_response     = 1'b1;
          default     : exp_route.restart_response = 1'b1;
        endcase
        busy_model[tag] = 1'b0; // released two edges later
        outstanding_model--;
      end
      route_slot[(cycles + 2) % 8] = exp_route;
      error_slot[(cycles + 4) % 8] = expected_errors(!good_parity, code);
    end
    next_cycle();
    response.valid = 1'b0;
  endtask

  task automatic response_burst(input int count);
    logic [7:0] tag;
    repeat (count) begin
      if (outstanding_model > 0 && ($unsigned($random(seed)) % 4) != 0) begin
        tag = pick_tag($unsigned($random(seed)) % tag_count);
      end else begin
        tag = 8'($unsigned($random(seed)) % 32); // may hit a free tag
      end
      send_response(tag, ($unsigned($random(seed)) % 4) != 0, codes[$unsigned($random(seed)) % 7]);
    end
    repeat (2) next_cycle(); // let releases land before the next command
  endtask

  // outputs are stable at the falling edge
  always @(negedge clock) begin
    int                         idx;
    ResponseControlInterfaceOut exp;
    logic [3:0]                 exp_flags;
    idx       = cycles % 8;
    exp       = route_slot[idx];
    exp_flags = {exp.read_response, exp.write_response, exp.wed_response, exp.restart_response};
    if ({response_control_out.read_response, response_control_out.write_response,
         response_control_out.wed_response, response_control_out.restart_response} !== exp_flags)
      report_mismatch("route flags", {response_control_out.read_response,
                      response_control_out.write_response, response_control_out.wed_response,
                      response_control_out.restart_response}, exp_flags);
    if (response_control_out.response.valid !== exp.response.valid)
      report_mismatch("response.valid", response_control_out.response.valid, exp.response.valid);
    if (exp.response.valid && response_control_out.response.response !== exp.response.response)
      report_mismatch("response.response", response_control_out.response.response,
                      exp.response.response);
    if (exp.response.valid &&
        response_control_out.response.cmd.cmd_type !== exp.response.cmd.cmd_type)
      report_mismatch("response.cmd.cmd_type", response_control_out.response.cmd.cmd_type,
                      exp.response.cmd.cmd_type);
    if (exp_flags != 4'b0 && response_control_out.response.cmd !== exp.response.cmd)
      report_mismatch("response.cmd", response_control_out.response.cmd, exp.response.cmd);
    if (response_error !== error_slot[idx])
      report_mismatch("response_error", response_error, error_slot[idx]);
    route_slot[idx] = '0;
    error_slot[idx] = '0;
    if (cmd_out.valid === 1'b1) seen_cmds++;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int          choice;
    logic [31:0] word;
    seed       = 32'h021ca36e;
    rstn       = 1'b0;
    enabled_in = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    wb_sel     = '1;
    response   = '0;
    enabled_model     = 1'b0;
    outstanding_model = 0;
    for (int i = 0; i < tag_count; i++) busy_model[i] = 1'b0;
    for (int i = 0; i < 8; i++) begin
      route_slot[i] = '0;
      error_slot[i] = '0;
    end
    repeat (5) @(posedge clock);
    #1;
    rstn       = 1'b1;
    enabled_in = 1'b1;
    next_cycle();
    enabled_model = 1'b1;

    repeat (300) begin
      choice = $unsigned($random(seed)) % 10;
      if (choice < 4 && outstanding_model < tag_count) begin
        wishbone_access(1'b1, 4'd0, $random(seed)); // random type, some invalid
      end else if (choice == 4) begin
        wishbone_access(1'b0, 4'd1, 32'd0);
      end else if (choice == 5) begin
        wishbone_access($random(seed), 4'(2 + $unsigned($random(seed)) % 14), $random(seed));
      end else if (choice < 9) begin
        response_burst(1 + $unsigned($random(seed)) % 4);
      end else begin
        enabled_in = 1'b0;
        next_cycle();
        enabled_model = 1'b0;
        response_burst(2);
        enabled_in = 1'b1;
        next_cycle();
        enabled_model = 1'b1;
      end
    end

    // fill every tag, then a write must stall until a response frees one
    while (outstanding_model < tag_count) begin
      word      = $random(seed);
      word[2:0] = 3'(1 + $unsigned($random(seed)) % 4);
      wishbone_access(1'b1, 4'd0, word);
    end
    word      = $random(seed);
    word[2:0] = 3'(1 + $unsigned($random(seed)) % 4);
    fork
      wishbone_access(1'b1, 4'd0, word);
      begin
        repeat (6) next_cycle();
        if (got_ack) begin
          other_errors++;
          $display("command write acknowledged at %0t while all tags were outstanding", $time);
        end
        send_response(pick_tag(0), 1'b1, DONE);
      end
    join
    wishbone_access(1'b0, 4'd1, 32'd0);

    while (outstanding_model > 0) response_burst(1 + $unsigned($random(seed)) % 4);
    wishbone_access(1'b0, 4'd1, 32'd0);
    repeat (8) next_cycle();
    if (seen_cmds != issued_cmds) report_mismatch("cmd_out pulse count", seen_cmds, issued_cmds);

    $display("%0d mismatches, %0d other errors", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
